// ==== src/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    localparam int XLEN  = 32;
    localparam int CSR_W = 12;

    // Implemented machine-mode CSR numbers
    typedef enum logic [CSR_W-1:0] {
        CSR_MVENDORID  = 12'hf11,
        CSR_MARCHID    = 12'hf12,
        CSR_MIMPID     = 12'hf13,
        CSR_MHARTID    = 12'hf14,
        CSR_MSTATUS    = 12'h300,
        CSR_MISA       = 12'h301,
        CSR_MIE        = 12'h304,
        CSR_MTVEC      = 12'h305,
        CSR_MCOUNTEREN = 12'h306,
        CSR_MSCRATCH   = 12'h340,
        CSR_MEPC       = 12'h341,
        CSR_MCAUSE     = 12'h342,
        CSR_MTVAL      = 12'h343,
        CSR_MIP        = 12'h344
    } csr_num_e;

    localparam logic [XLEN-1:0] MISA_VALUE      = 32'h4000_0100; // RV32I
    localparam logic [XLEN-1:0] MVENDORID_VALUE = 32'h0000_0000; // Non-commercial
    localparam logic [XLEN-1:0] MARCHID_VALUE   = 32'h0000_0000;
    localparam logic [XLEN-1:0] MIMPID_VALUE    = 32'h0000_0001;

    // Only writable mstatus fields
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    typedef struct packed {
        logic            valid;
        logic            hit;
        logic [XLEN-1:0] rdata;
    } csr_rsp_t;

endpackage

`default_nettype wire

// ==== src/csr_req_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface csr_req_if;
    import csr_pkg::*;

    logic              req;    // One-cycle pulse
    logic              we;
    logic [1:0]        hart;
    logic [CSR_W-1:0]  num;
    logic [XLEN-1:0]   wdata;
    logic [XLEN/8-1:0] wstrb;

    modport source (
        output req, we, hart, num, wdata, wstrb
    );

    modport sink (
        input req, we, hart, num, wdata, wstrb
    );

endinterface

`default_nettype wire

// ==== src/axil_csr_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module axil_csr_frontend #(
    parameter int N_HARTS = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic [15:0]                awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [csr_pkg::XLEN-1:0]   wdata,
    input  logic [csr_pkg::XLEN/8-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,

    input  logic [15:0]                araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [csr_pkg::XLEN-1:0]   rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,

    csr_req_if.source                  csr,
    input  csr_pkg::csr_rsp_t          rsp
);
    import csr_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_RSP,
        ST_RESP_W,
        ST_RESP_R
    } state_e;

    state_e            state;
    logic              is_write_q;
    logic [1:0]        hart_q;
    logic [CSR_W-1:0]  num_q;
    logic [XLEN-1:0]   wdata_q;
    logic [XLEN/8-1:0] wstrb_q;
    axi_resp_e         resp_q;
    logic [XLEN-1:0]   rdata_q;
    logic              hart_ok;

    // Read wins when both channels arrive together
    assign arready = (state == ST_IDLE) && arvalid;
    assign awready = (state == ST_IDLE) && awvalid && wvalid && !arvalid;
    assign wready  = awready;

    assign hart_ok = (int'(hart_q) < N_HARTS);

    assign csr.req   = (state == ST_ISSUE) && hart_ok;
    assign csr.we    = is_write_q;
    assign csr.hart  = hart_q;
    assign csr.num   = num_q;
    assign csr.wdata = wdata_q;
    assign csr.wstrb = wstrb_q;

    assign bvalid = (state == ST_RESP_W);
    assign rvalid = (state == ST_RESP_R);
    assign bresp  = resp_q;
    assign rresp  = resp_q;
    assign rdata  = rdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (arready || awready) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (hart_ok) begin
                        state <= ST_WAIT_RSP;
                    end else begin
                        state <= is_write_q ? ST_RESP_W : ST_RESP_R; // Range error
                    end
                end
                ST_WAIT_RSP: begin
                    if (rsp.valid) begin
                        state <= is_write_q ? ST_RESP_W : ST_RESP_R;
                    end
                end
                ST_RESP_W: begin
                    if (bready) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RESP_R: begin
                    if (rready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Byte offset bits of the address are ignored
    always_ff @(posedge clk) begin
        if (arready) begin
            is_write_q <= 1'b0;
            hart_q     <= araddr[15:14];
            num_q      <= araddr[13:2];
        end else if (awready) begin
            is_write_q <= 1'b1;
            hart_q     <= awaddr[15:14];
            num_q      <= awaddr[13:2];
            wdata_q    <= wdata;
            wstrb_q    <= wstrb;
        end

        if (state == ST_ISSUE && !hart_ok) begin
            resp_q  <= SLVERR;
            rdata_q <= '0;
        end else if (state == ST_WAIT_RSP && rsp.valid) begin
            if (rsp.hit) begin
                resp_q <= OKAY;
            end else begin
                resp_q <= SLVERR;
            end
            rdata_q <= (rsp.hit && !is_write_q) ? rsp.rdata : '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/hart_csr_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module hart_csr_bank #(
    parameter int HART_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    csr_req_if.sink                  csr,
    input  logic                     trap_valid,
    input  logic [csr_pkg::XLEN-1:0] trap_cause,
    input  logic [csr_pkg::XLEN-1:0] trap_pc,
    output csr_pkg::csr_rsp_t        rsp
);
    import csr_pkg::*;

    localparam logic [XLEN-1:0] MEPC_MASK  = 32'hffff_fffc;
    localparam logic [XLEN-1:0] MTVEC_MASK = 32'hffff_fffd; // Direct or vectored only

    logic            mstatus_mie;
    logic            mstatus_mpie;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mcounteren_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mtval_q;

    csr_num_e        num;
    logic            sel;
    logic            known;
    logic            read_only;
    logic            wr_en;
    logic [XLEN-1:0] cur_val;
    logic [XLEN-1:0] wr_val;
    logic [XLEN-1:0] mstatus_val;

    logic            rsp_valid_q;
    logic            rsp_hit_q;
    logic [XLEN-1:0] rsp_rdata_q;

    function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0]   old_val,
                                                    input logic [XLEN-1:0]   new_val,
                                                    input logic [XLEN/8-1:0] strb);
        logic [XLEN-1:0] res;
        res = old_val;
        for (int b = 0; b < XLEN / 8; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign num       = csr_num_e'(csr.num);
    assign sel       = csr.req && (csr.hart == 2'(HART_ID));
    assign read_only = (csr.num[11:10] == 2'b11);

    always_comb begin
        mstatus_val                = '0;
        mstatus_val[MSTATUS_MIE]   = mstatus_mie;
        mstatus_val[MSTATUS_MPIE]  = mstatus_mpie;
    end

    always_comb begin
        known   = 1'b1;
        cur_val = '0;
        case (num)
            CSR_MVENDORID:  cur_val = MVENDORID_VALUE;
            CSR_MARCHID:    cur_val = MARCHID_VALUE;
            CSR_MIMPID:     cur_val = MIMPID_VALUE;
            CSR_MHARTID:    cur_val = XLEN'(HART_ID);
            CSR_MSTATUS:    cur_val = mstatus_val;
            CSR_MISA:       cur_val = MISA_VALUE;
            CSR_MIE:        cur_val = mie_q;
            CSR_MTVEC:      cur_val = mtvec_q;
            CSR_MCOUNTEREN: cur_val = mcounteren_q;
            CSR_MSCRATCH:   cur_val = mscratch_q;
            CSR_MEPC:       cur_val = mepc_q;
            CSR_MCAUSE:     cur_val = mcause_q;
            CSR_MTVAL:      cur_val = mtval_q;
            CSR_MIP:        cur_val = '0; // No pending sources
            default:        known   = 1'b0;
        endcase
    end

    assign wr_en  = sel && csr.we && known && !read_only;
    assign wr_val = merge_bytes(cur_val, csr.wdata, csr.wstrb);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_q        <= '0;
            mtvec_q      <= '0;
            mcounteren_q <= '0;
            mscratch_q   <= '0;
            mepc_q       <= '0;
            mcause_q     <= '0;
            mtval_q      <= '0;
        end else begin
            if (wr_en) begin
                case (num)
                    CSR_MSTATUS: begin
                        mstatus_mie  <= wr_val[MSTATUS_MIE];
                        mstatus_mpie <= wr_val[MSTATUS_MPIE];
                    end
                    CSR_MIE:        mie_q        <= wr_val;
                    CSR_MTVEC:      mtvec_q      <= wr_val & MTVEC_MASK;
                    CSR_MCOUNTEREN: mcounteren_q <= wr_val;
                    CSR_MSCRATCH:   mscratch_q   <= wr_val;
                    CSR_MEPC:       mepc_q       <= wr_val & MEPC_MASK;
                    CSR_MCAUSE:     mcause_q     <= wr_val;
                    CSR_MTVAL:      mtval_q      <= wr_val;
                    default: ;
                endcase
            end

            // Trap entry overrides a host write on the same edge
            if (trap_valid) begin
                mepc_q       <= trap_pc & MEPC_MASK;
                mcause_q     <= trap_cause;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
            rsp_hit_q   <= 1'b0;
        end else begin
            rsp_valid_q <= sel;
            rsp_hit_q   <= sel && known && !(csr.we && read_only);
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            rsp_rdata_q <= cur_val;
        end
    end

    assign rsp = '{valid: rsp_valid_q, hit: rsp_hit_q, rdata: rsp_rdata_q};

endmodule

`default_nettype wire

// ==== src/csr_rsp_collect.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_rsp_collect #(
    parameter int N_HARTS = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  csr_pkg::csr_rsp_t bank_rsp [N_HARTS],
    output csr_pkg::csr_rsp_t rsp
);
    import csr_pkg::*;

    csr_rsp_t        pick;
    logic            valid_q;
    logic            hit_q;
    logic [XLEN-1:0] rdata_q;

    // Walk down so the lowest valid index is kept
    always_comb begin
        pick = '0;
        for (int i = N_HARTS - 1; i >= 0; i--) begin
            if (bank_rsp[i].valid) begin
                pick = bank_rsp[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            hit_q   <= 1'b0;
        end else begin
            valid_q <= pick.valid;
            hit_q   <= pick.valid && pick.hit; // Valid without hit marks a miss
        end
    end

    always_ff @(posedge clk) begin
        if (pick.valid) begin
            rdata_q <= pick.rdata;
        end
    end

    assign rsp = '{valid: valid_q, hit: hit_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== src/csr_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_subsystem #(
    parameter int N_HARTS = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic [15:0]                awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [csr_pkg::XLEN-1:0]   wdata,
    input  logic [csr_pkg::XLEN/8-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,

    input  logic [15:0]                araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [csr_pkg::XLEN-1:0]   rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,

    input  logic [N_HARTS-1:0]         trap_valid,
    input  logic [csr_pkg::XLEN-1:0]   trap_cause,
    input  logic [csr_pkg::XLEN-1:0]   trap_pc
);
    import csr_pkg::*;

    csr_req_if csr_bus ();

    csr_rsp_t bank_rsp [N_HARTS];
    csr_rsp_t coll_rsp;

    axil_csr_frontend #(
        .N_HARTS (N_HARTS)
    ) frontend_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .csr     (csr_bus.source),
        .rsp     (coll_rsp)
    );

    // One bank per hart on the shared request bus
    for (genvar g = 0; g < N_HARTS; g++) begin : g_bank
        hart_csr_bank #(
            .HART_ID (g)
        ) bank_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .csr        (csr_bus.sink),
            .trap_valid (trap_valid[g]),
            .trap_cause (trap_cause),
            .trap_pc    (trap_pc),
            .rsp        (bank_rsp[g])
        );
    end

    csr_rsp_collect #(
        .N_HARTS (N_HARTS)
    ) collect_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .bank_rsp (bank_rsp),
        .rsp      (coll_rsp)
    );

endmodule

`default_nettype wire

// ==== sim/tb_csr_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_csr_subsystem;
    import csr_pkg::*;

    localparam int          N_HARTS        = 4;
    localparam int          TIMEOUT_CYCLES = 50;
    localparam logic [31:0] LFSR_SEED      = 32'ha2a9;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
    localparam logic [15:0] PROBE_ADDR     = {2'd0, 12'h7c0, 2'b00};

    logic              clk = 1'b0;
    logic              rst_n;
    logic [15:0]       awaddr;
    logic              awvalid;
    logic              awready;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [15:0]       araddr;
    logic              arvalid;
    logic              arready;
    logic [31:0]       rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;
    logic [N_HARTS-1:0] trap_valid;
    logic [31:0]       trap_cause;
    logic [31:0]       trap_pc;

    logic [31:0] lfsr;
    logic [31:0] shadow [int]; // Keyed by {hart, csr number}
    int          value_errors;
    int          protocol_errors;
    int          timeouts;
    logic        timed_out;

    csr_num_e all_csrs [14] = '{CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
                                CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MCOUNTEREN,
                                CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP};
    csr_num_e rw_csrs [5] = '{CSR_MSCRATCH, CSR_MTVEC, CSR_MEPC, CSR_MIE, CSR_MCAUSE};

    csr_subsystem #(
        .N_HARTS (N_HARTS)
    ) csr_subsystem_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .trap_valid (trap_valid),
        .trap_cause (trap_cause),
        .trap_pc    (trap_pc)
    );

    always #5 clk = ~clk;

    rd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        $display("Read response changed or dropped before rready");
        protocol_errors++;
    end

    wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        $display("Write response changed or dropped before bready");
        protocol_errors++;
    end

    no_accept: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid || bvalid) |-> !(arready || awready))
    else begin
        $display("A new address was accepted while a response was pending");
        protocol_errors++;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? LFSR_TAPS : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic int key(input logic [1:0] h, input logic [11:0] num);
        return int'({h, num});
    endfunction

    function automatic logic is_known(input logic [11:0] num);
        foreach (all_csrs[i]) begin
            if (all_csrs[i] == num) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic void model_reset();
        logic [31:0] v;
        for (int h = 0; h < N_HARTS; h++) begin
            foreach (all_csrs[i]) begin
                case (all_csrs[i])
                    CSR_MVENDORID: v = MVENDORID_VALUE;
                    CSR_MARCHID:   v = MARCHID_VALUE;
                    CSR_MIMPID:    v = MIMPID_VALUE;
                    CSR_MHARTID:   v = 32'(h);
                    CSR_MISA:      v = MISA_VALUE;
                    default:       v = '0;
                endcase
                shadow[key(2'(h), all_csrs[i])] = v;
            end
        end
    endfunction

    // Byte merge then WARL masks; constant CSRs and mip ignore writes
    function automatic void model_write(input logic [1:0] h, input logic [11:0] num,
                                        input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] v;
        v = shadow[key(h, num)];
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                v[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        case (num)
            CSR_MSTATUS: v = v & ((32'(1) << MSTATUS_MIE) | (32'(1) << MSTATUS_MPIE));
            CSR_MEPC:    v = v & 32'hffff_fffc;
            CSR_MTVEC:   v = v & 32'hffff_fffd;
            CSR_MIE, CSR_MCOUNTEREN, CSR_MSCRATCH, CSR_MCAUSE, CSR_MTVAL: ;
            default:     v = shadow[key(h, num)];
        endcase
        shadow[key(h, num)] = v;
    endfunction

    function automatic void model_trap(input logic [1:0] h, input logic [31:0] cause,
                                       input logic [31:0] pc);
        logic [31:0] v;
        v = shadow[key(h, CSR_MSTATUS)];
        shadow[key(h, CSR_MSTATUS)] = v[MSTATUS_MIE] ? (32'(1) << MSTATUS_MPIE) : 32'h0;
        shadow[key(h, CSR_MEPC)]    = pc & 32'hffff_fffc;
        shadow[key(h, CSR_MCAUSE)]  = cause;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    function automatic logic sig_level(input int which);
        case (which)
            0:       return arready;
            1:       return awready && wready;
            2:       return rvalid;
            default: return bvalid;
        endcase
    endfunction

    task automatic wait_high(input int which, input string what, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timeout waiting for %s", what);
                timeouts++;
                timed_out = 1'b1;
                return;
            end
        end while (!sig_level(which));
    endtask

    // Random back-pressure with a read probe that must not be taken
    task automatic finish_response(input logic is_write, input string name,
                                   output logic [1:0] resp, output logic [31:0] data);
        logic [1:0]  resp0;
        logic [31:0] data0;
        int          stall;
        resp0 = is_write ? bresp : rresp;
        data0 = rdata;
        stall = int'(rand_bits(2));
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            araddr  <= PROBE_ADDR;
            arvalid <= 1'b1;
            @(negedge clk);
            assert ((is_write ? bvalid : rvalid) && !arready && !awready) else begin
                $display("%s: response dropped or address taken during back-pressure", name);
                protocol_errors++;
            end
            assert ((is_write ? bresp : rresp) == resp0 && rdata == data0) else begin
                $display("%s: response changed before the handshake", name);
                protocol_errors++;
            end
        end
        @(posedge clk);
        if (is_write) begin
            bready <= 1'b1;
        end else begin
            rready <= 1'b1;
        end
        @(negedge clk);
        resp = is_write ? bresp : rresp;
        data = rdata;
        @(posedge clk);
        bready  <= 1'b0;
        rready  <= 1'b0;
        arvalid <= 1'b0;
    endtask

    task automatic axil_read(input string name, input logic [1:0] h, input logic [11:0] num,
                             output logic [1:0] resp, output logic [31:0] data, output int lat);
        if (timed_out) return;
        @(posedge clk);
        araddr  <= {h, num, 2'b00};
        arvalid <= 1'b1;
        wait_high(0, {name, " arready"}, lat);
        if (timed_out) return;
        @(posedge clk);
        arvalid <= 1'b0;
        wait_high(2, {name, " rvalid"}, lat);
        if (timed_out) return;
        finish_response(1'b0, name, resp, data);
    endtask

    task automatic axil_write(input string name, input logic [1:0] h, input logic [11:0] num,
                              input logic [31:0] data, input logic [3:0] strb,
                              output logic [1:0] resp, output int lat);
        logic [31:0] unused_data;
        if (timed_out) return;
        @(posedge clk);
        awaddr  <= {h, num, 2'b00};
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        wait_high(1, {name, " awready"}, lat);
        if (timed_out) return;
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        wait_high(3, {name, " bvalid"}, lat);
        if (timed_out) return;
        finish_response(1'b1, name, resp, unused_data);
    endtask

    task automatic read_check(input string name, input logic [1:0] h, input logic [11:0] num);
        logic [1:0]  resp;
        logic [31:0] data;
        int          lat;
        axi_resp_e   exp_resp;
        logic [31:0] exp_data;
        int          exp_lat;
        axil_read(name, h, num, resp, data, lat);
        if (timed_out) return;
        exp_lat  = (int'(h) >= N_HARTS) ? 2 : 4;
        exp_resp = SLVERR;
        exp_data = '0;
        if (int'(h) < N_HARTS && is_known(num)) begin
            exp_resp = OKAY;
            exp_data = shadow[key(h, num)];
        end
        check_val({name, " rresp"}, 32'(exp_resp), 32'(resp));
        check_val({name, " rdata"}, exp_data, data);
        check_val({name, " latency"}, 32'(exp_lat), 32'(lat));
    endtask

    task automatic write_check(input string name, input logic [1:0] h, input logic [11:0] num,
                               input logic [31:0] data, input logic [3:0] strb);
        logic [1:0] resp;
        int         lat;
        axi_resp_e  exp_resp;
        int         exp_lat;
        axil_write(name, h, num, data, strb, resp, lat);
        if (timed_out) return;
        exp_lat  = (int'(h) >= N_HARTS) ? 2 : 4;
        exp_resp = SLVERR;
        if (int'(h) < N_HARTS && is_known(num) && num[11:10] != 2'b11) begin
            exp_resp = OKAY;
            model_write(h, num, data, strb);
        end
        check_val({name, " bresp"}, 32'(exp_resp), 32'(resp));
        check_val({name, " latency"}, 32'(exp_lat), 32'(lat));
    endtask

    initial begin
        logic [1:0]  h;
        logic [11:0] c;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] cause;
        logic [31:0] pc;
        rst_n      <= 1'b0;
        awaddr     <= '0;
        awvalid    <= 1'b0;
        wdata      <= '0;
        wstrb      <= '0;
        wvalid     <= 1'b0;
        bready     <= 1'b0;
        araddr     <= '0;
        arvalid    <= 1'b0;
        rready     <= 1'b0;
        trap_valid <= '0;
        trap_cause <= '0;
        trap_pc    <= '0;
        lfsr            = LFSR_SEED;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        timed_out       = 1'b0;
        model_reset();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        for (int hi = 0; hi < N_HARTS; hi++) begin
            foreach (all_csrs[i]) begin
                read_check($sformatf("reset h%0d %03h", hi, all_csrs[i]), 2'(hi), all_csrs[i]);
            end
        end

        for (int n = 0; n < 40; n++) begin
            h    = 2'(rand_bits(2));
            c    = rw_csrs[rand_bits(3) % 5];
            data = rand_bits(32);
            strb = 4'(rand_bits(4));
            write_check($sformatf("write %0d h%0d %03h", n, h, c), h, c, data, strb);
            read_check($sformatf("readback %0d h%0d %03h", n, h, c), h, c);
        end
        for (int hi = 0; hi < N_HARTS; hi++) begin
            foreach (rw_csrs[i]) begin
                read_check($sformatf("sweep h%0d %03h", hi, rw_csrs[i]), 2'(hi), rw_csrs[i]);
            end
        end

        read_check("unknown csr read", 2'd0, 12'h7c0);
        write_check("unknown csr write", 2'd0, 12'h7c0, rand_bits(32), 4'hf);
        if (N_HARTS < 4) begin
            read_check("hart range read", 2'd3, CSR_MSCRATCH);
            write_check("hart range write", 2'd3, CSR_MSCRATCH, rand_bits(32), 4'hf);
        end else begin
            read_check("unknown csr hart 3 read", 2'd3, 12'h7ff);
            write_check("unknown csr hart 3 write", 2'd3, 12'h7ff, rand_bits(32), 4'hf);
        end
        for (int hi = 0; hi < N_HARTS; hi++) begin
            write_check($sformatf("mhartid write h%0d", hi), 2'(hi), CSR_MHARTID,
                        rand_bits(32), 4'hf);
            read_check($sformatf("mhartid after write h%0d", hi), 2'(hi), CSR_MHARTID);
        end

        // MIE set on the trapping hart and its neighbour
        write_check("mstatus h1", 2'd1, CSR_MSTATUS, 32'(1) << MSTATUS_MIE, 4'hf);
        write_check("mstatus h2", 2'd2, CSR_MSTATUS, 32'(1) << MSTATUS_MIE, 4'hf);
        read_check("mstatus before trap h2", 2'd2, CSR_MSTATUS);
        cause = rand_bits(32);
        pc    = rand_bits(32);
        @(posedge clk);
        trap_valid <= 4'b0100;
        trap_cause <= cause;
        trap_pc    <= pc;
        @(posedge clk);
        trap_valid <= '0;
        model_trap(2'd2, cause, pc);
        for (int hi = 1; hi <= 2; hi++) begin
            read_check($sformatf("trap mepc h%0d", hi), 2'(hi), CSR_MEPC);
            read_check($sformatf("trap mcause h%0d", hi), 2'(hi), CSR_MCAUSE);
            read_check($sformatf("trap mstatus h%0d", hi), 2'(hi), CSR_MSTATUS);
        end

        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
src/csr_pkg.sv
src/csr_req_if.sv
src/axil_csr_frontend.sv
src/hart_csr_bank.sv
src/csr_rsp_collect.sv
src/csr_subsystem.sv
sim/tb_csr_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module tb_csr_subsystem -o tb_csr_subsystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_csr_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    exit 0
fi
exit 1
